//--- hdl/irq_ctrl.sv
module irq_ctrl #(
    parameter int NumExtIrq = periph_cfg_pkg::NumExtIrq
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 we_i,
    input  logic [periph_cfg_pkg::RegionSel-1:0] off_i,
    input  logic [periph_cfg_pkg::DataWidth-1:0] wdata_i,
    output logic [periph_cfg_pkg::DataWidth-1:0] rdata_o,
    input  logic                                 timer_irq_i,
    input  logic [NumExtIrq-1:0]                 ext_irq_i,
    output logic                                 irq_o
);

    import periph_cfg_pkg::*;

    localparam int ExtSrcBase = TimerSrcId + 1;

    logic [NumSources-1:0] src_d;
    logic [NumSources-1:0] src_q;
    logic [NumSources-1:0] enable_q;
    logic [NumSources-1:0] pending;
    logic [SrcIdWidth-1:0] claim_id;

    // ------------------------------------------------------------------------
    // Source gathering
    // ------------------------------------------------------------------------

    // ID 0 is reserved, IDs past the last external line stay low
    always_comb begin
        src_d             = '0;
        src_d[TimerSrcId] = timer_irq_i;
        for (int i = 0; i < NumExtIrq; i++) begin
            src_d[ExtSrcBase + i] = ext_irq_i[i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q    <= '0;
            enable_q <= '0;
        end else begin
            src_q <= src_d;
            if (we_i && (off_i == IrqEnableOff)) begin
                enable_q <= wdata_i[NumSources-1:0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Pending and claim
    // ------------------------------------------------------------------------
    assign pending = src_q & enable_q;

    // Highest ID wins
    always_comb begin
        claim_id = '0;
        for (int i = 1; i < NumSources; i++) begin
            if (pending[i]) begin
                claim_id = SrcIdWidth'(i);
            end
        end
    end

    always_comb begin
        unique case (off_i)
            IrqEnableOff:  rdata_o = DataWidth'(enable_q);
            IrqPendingOff: rdata_o = DataWidth'(pending);
            IrqClaimOff:   rdata_o = DataWidth'(claim_id);
            default:       rdata_o = '0;
        endcase
    end

    assign irq_o = |pending;

endmodule

//--- hdl/periph_cfg_pkg.sv
package periph_cfg_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------------
    localparam int AddrWidth   = 16;
    localparam int DataWidth   = 32;
    // Lowest bit of the region field, addr[15:12]
    localparam int RegionSel   = 12;
    localparam int RegionWidth = AddrWidth - RegionSel;

    localparam logic [RegionWidth-1:0] TimerRegionId = 4'd0;
    localparam logic [RegionWidth-1:0] IrqRegionId   = 4'd1;

    // Timer registers
    localparam logic [RegionSel-1:0] TimerCountOff = 12'h000;
    localparam logic [RegionSel-1:0] TimerCmpOff   = 12'h004;
    localparam logic [RegionSel-1:0] TimerCtrlOff  = 12'h008;

    // Interrupt controller registers
    localparam logic [RegionSel-1:0] IrqEnableOff  = 12'h000;
    localparam logic [RegionSel-1:0] IrqPendingOff = 12'h004;
    localparam logic [RegionSel-1:0] IrqClaimOff   = 12'h008;

    localparam int NumSources = 8;
    localparam int SrcIdWidth = $clog2(NumSources);
    localparam int TimerSrcId = 1;
    localparam int NumExtIrq  = 6;

    localparam logic [DataWidth-1:0] ErrRdata = 32'hDEAD_BEEF;

endpackage

//--- hdl/periph_decode.sv
module periph_decode (
    input  logic                                 req_valid_i,
    output logic                                 req_ready_o,
    input  reg_bus_pkg::reg_req_t                req_i,
    output logic                                 resp_valid_o,
    input  logic                                 resp_ready_i,
    output reg_bus_pkg::reg_resp_t               resp_o,
    output logic                                 tmr_we_o,
    output logic [periph_cfg_pkg::RegionSel-1:0] tmr_off_o,
    output logic [periph_cfg_pkg::DataWidth-1:0] tmr_wdata_o,
    input  logic [periph_cfg_pkg::DataWidth-1:0] tmr_rdata_i,
    output logic                                 irq_we_o,
    output logic [periph_cfg_pkg::RegionSel-1:0] irq_off_o,
    output logic [periph_cfg_pkg::DataWidth-1:0] irq_wdata_o,
    input  logic [periph_cfg_pkg::DataWidth-1:0] irq_rdata_i
);

    import periph_cfg_pkg::*;

    logic [RegionWidth-1:0] region;
    logic                   hs;
    logic                   wr_hs;

    assign region = req_i.addr[AddrWidth-1:RegionSel];

    // Request passes straight through while the response slice has room
    assign req_ready_o  = resp_ready_i;
    assign resp_valid_o = req_valid_i;
    assign hs           = req_valid_i & resp_ready_i;
    assign wr_hs        = hs & req_i.write;

    assign tmr_we_o    = wr_hs && (region == TimerRegionId);
    assign tmr_off_o   = req_i.addr[RegionSel-1:0];
    assign tmr_wdata_o = req_i.wdata;
    assign irq_we_o    = wr_hs && (region == IrqRegionId);
    assign irq_off_o   = req_i.addr[RegionSel-1:0];
    assign irq_wdata_o = req_i.wdata;

    // Unmapped regions get the error word
    always_comb begin
        resp_o.error = 1'b0;
        unique case (region)
            TimerRegionId: resp_o.rdata = tmr_rdata_i;
            IrqRegionId:   resp_o.rdata = irq_rdata_i;
            default: begin
                resp_o.rdata = ErrRdata;
                resp_o.error = 1'b1;
            end
        endcase
    end

endmodule

//--- hdl/periph_subsystem.sv
module periph_subsystem #(
    parameter int NumExtIrq = periph_cfg_pkg::NumExtIrq
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 req_valid_i,
    output logic                                 req_ready_o,
    input  logic [periph_cfg_pkg::AddrWidth-1:0] req_addr_i,
    input  logic                                 req_write_i,
    input  logic [periph_cfg_pkg::DataWidth-1:0] req_wdata_i,
    output logic                                 resp_valid_o,
    input  logic                                 resp_ready_i,
    output logic [periph_cfg_pkg::DataWidth-1:0] resp_rdata_o,
    output logic                                 resp_error_o,
    input  logic [NumExtIrq-1:0]                 ext_irq_i,
    output logic                                 irq_o
);

    import periph_cfg_pkg::*;
    import reg_bus_pkg::*;

    reg_req_t  req_in;
    reg_req_t  req_q;
    reg_resp_t resp_d;
    reg_resp_t resp_q;
    logic      req_q_valid;
    logic      req_q_ready;
    logic      resp_d_valid;
    logic      resp_d_ready;

    logic                 tmr_we;
    logic [RegionSel-1:0] tmr_off;
    logic [DataWidth-1:0] tmr_wdata;
    logic [DataWidth-1:0] tmr_rdata;
    logic                 irq_we;
    logic [RegionSel-1:0] irq_off;
    logic [DataWidth-1:0] irq_wdata;
    logic [DataWidth-1:0] irq_rdata;
    logic                 timer_irq;

    assign req_in.addr  = req_addr_i;
    assign req_in.write = req_write_i;
    assign req_in.wdata = req_wdata_i;

    assign resp_rdata_o = resp_q.rdata;
    assign resp_error_o = resp_q.error;

    // ------------------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------------------
    reg_slice #(
        .payload_t ( reg_req_t )
    ) u_req_slice (
        .clk_i    ( clk_i       ),
        .arst_n_i ( arst_n_i    ),
        .valid_i  ( req_valid_i ),
        .ready_o  ( req_ready_o ),
        .data_i   ( req_in      ),
        .valid_o  ( req_q_valid ),
        .ready_i  ( req_q_ready ),
        .data_o   ( req_q       )
    );

    periph_decode u_decode (
        .req_valid_i  ( req_q_valid  ),
        .req_ready_o  ( req_q_ready  ),
        .req_i        ( req_q        ),
        .resp_valid_o ( resp_d_valid ),
        .resp_ready_i ( resp_d_ready ),
        .resp_o       ( resp_d       ),
        .tmr_we_o     ( tmr_we       ),
        .tmr_off_o    ( tmr_off      ),
        .tmr_wdata_o  ( tmr_wdata    ),
        .tmr_rdata_i  ( tmr_rdata    ),
        .irq_we_o     ( irq_we       ),
        .irq_off_o    ( irq_off      ),
        .irq_wdata_o  ( irq_wdata    ),
        .irq_rdata_i  ( irq_rdata    )
    );

    reg_slice #(
        .payload_t ( reg_resp_t )
    ) u_resp_slice (
        .clk_i    ( clk_i        ),
        .arst_n_i ( arst_n_i     ),
        .valid_i  ( resp_d_valid ),
        .ready_o  ( resp_d_ready ),
        .data_i   ( resp_d       ),
        .valid_o  ( resp_valid_o ),
        .ready_i  ( resp_ready_i ),
        .data_o   ( resp_q       )
    );

    // ------------------------------------------------------------------------
    // Peripherals
    // ------------------------------------------------------------------------
    periph_timer u_timer (
        .clk_i    ( clk_i     ),
        .arst_n_i ( arst_n_i  ),
        .we_i     ( tmr_we    ),
        .off_i    ( tmr_off   ),
        .wdata_i  ( tmr_wdata ),
        .rdata_o  ( tmr_rdata ),
        .irq_o    ( timer_irq )
    );

    irq_ctrl #(
        .NumExtIrq ( NumExtIrq )
    ) u_irq_ctrl (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .we_i        ( irq_we    ),
        .off_i       ( irq_off   ),
        .wdata_i     ( irq_wdata ),
        .rdata_o     ( irq_rdata ),
        .timer_irq_i ( timer_irq ),
        .ext_irq_i   ( ext_irq_i ),
        .irq_o       ( irq_o     )
    );

endmodule

//--- hdl/periph_timer.sv
module periph_timer (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 we_i,
    input  logic [periph_cfg_pkg::RegionSel-1:0] off_i,
    input  logic [periph_cfg_pkg::DataWidth-1:0] wdata_i,
    output logic [periph_cfg_pkg::DataWidth-1:0] rdata_o,
    output logic                                 irq_o
);

    import periph_cfg_pkg::*;

    logic [DataWidth-1:0] count_q;
    logic [DataWidth-1:0] cmp_q;
    logic                 en_q;
    logic                 irq_q;
    logic                 ctrl_we;

    assign ctrl_we = we_i && (off_i == TimerCtrlOff);

    // Writing the control register restarts the count
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            en_q    <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (ctrl_we) begin
                en_q    <= wdata_i[0];
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
            if (we_i && (off_i == TimerCmpOff)) begin
                cmp_q <= wdata_i;
            end
            irq_q <= en_q && (count_q >= cmp_q);
        end
    end

    always_comb begin
        unique case (off_i)
            TimerCountOff: rdata_o = count_q;
            TimerCmpOff:   rdata_o = cmp_q;
            TimerCtrlOff:  rdata_o = DataWidth'(en_q);
            default:       rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

//--- hdl/reg_bus_pkg.sv
package reg_bus_pkg;

    // ------------------------------------------------------------------------
    // Register port payloads
    // ------------------------------------------------------------------------

    // Request carried from the initiator into the access stage
    typedef struct packed {
        logic [periph_cfg_pkg::AddrWidth-1:0] addr;
        logic                                 write;
        logic [periph_cfg_pkg::DataWidth-1:0] wdata;
    } reg_req_t;

    // Response, one per request, in request order
    typedef struct packed {
        logic [periph_cfg_pkg::DataWidth-1:0] rdata;
        logic                                 error;
    } reg_resp_t;

endpackage

//--- hdl/reg_slice.sv
module reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Full throughput: accept when empty or when the entry leaves now
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module periph_subsystem_tb \
    -Mdir obj_dir -o sim_bin &&
./obj_dir/sim_bin | tee /dev/stderr | grep "Test completed successfully" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation did not pass"; exit 1; }

//--- sim.f
hdl/periph_cfg_pkg.sv
hdl/reg_bus_pkg.sv
hdl/reg_slice.sv
hdl/periph_timer.sv
hdl/irq_ctrl.sv
hdl/periph_decode.sv
hdl/periph_subsystem.sv
verification/tb_clkgen.sv
verification/periph_subsystem_assert.sv
verification/periph_subsystem_tb.sv

//--- verification/periph_patterns.txt
// Columns: op addr data aux, all hex. op 0 write (aux = expected error), 1 read (data, aux =
// expected rdata, error), 2 set ext_irq_i, 3 poll read for data, 4 irq_o = aux, e end test, f end
0 0004 00001234 0
1 0004 00001234 0
0 1000 000000a5 0
1 1000 000000a5 0
1 000c 00000000 0
1 100c 00000000 0
1 0000 00000000 0
e 0 0 0
1 2000 deadbeef 1
1 f010 deadbeef 1
0 3004 00000055 1
1 0004 00001234 0
1 1000 000000a5 0
e 0 0 0
0 1000 0000000c 0
2 0 0000003f 0
1 1008 00000003 0
1 1004 0000000c 0
4 0 0 1
0 1000 000000fc 0
1 1008 00000007 0
0 1000 00000000 0
1 1008 00000000 0
4 0 0 0
2 0 00000000 0
e 0 0 0
0 0004 00000014 0
0 1000 00000002 0
0 0008 00000001 0
3 1008 00000001 0
4 0 0 1
0 0008 00000000 0
3 1008 00000000 0
4 0 0 0
1 0008 00000000 0
e 0 0 0
0 0004 cafe0001 0
1 0004 cafe0001 0
0 2000 12345678 1
1 0004 cafe0001 0
0 1000 00000081 0
1 1000 00000081 0
1 4abc deadbeef 1
1 1008 00000000 0
1 0008 00000000 0
0 0004 00000000 0
1 0004 00000000 0
e 0 0 0
f 0 0 0

//--- verification/periph_subsystem_assert.sv
module periph_subsystem_assert (
    input logic                                       clk_i,
    input logic                                       arst_n_i,
    input logic                                       req_valid_i,
    input logic                                       req_ready_i,
    input logic [$bits(reg_bus_pkg::reg_req_t)-1:0]   req_payload_i,
    input logic                                       resp_valid_i,
    input logic                                       resp_ready_i,
    input logic [$bits(reg_bus_pkg::reg_resp_t)-1:0]  resp_payload_i,
    input logic                                       irq_i
);

    // Stalled request stays put
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_payload_i))
    else $error("request dropped or changed while stalled");

    // Stalled response stays put
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_payload_i))
    else $error("response dropped or changed while stalled");

    assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !resp_valid_i && !irq_i)
    else $error("response valid or interrupt high right after reset");

endmodule

//--- verification/periph_subsystem_tb.sv
module periph_subsystem_tb;

    import periph_cfg_pkg::*;
    import reg_bus_pkg::*;

    localparam int NumExt    = 6;
    localparam int MaxWords  = 256;
    localparam int PollLimit = 200;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    logic [AddrWidth-1:0] req_addr_i;
    logic                 req_write_i;
    logic [DataWidth-1:0] req_wdata_i;
    logic                 resp_valid_o;
    logic                 resp_ready_i;
    logic [DataWidth-1:0] resp_rdata_o;
    logic                 resp_error_o;
    logic [NumExt-1:0]    ext_irq_i;
    logic                 irq_o;

    logic [31:0] pat_mem [0:MaxWords-1];
    reg_resp_t   exp_q[$];
    logic        full_q[$];
    reg_resp_t   last_resp;
    int          err_cnt = 0;
    int          cycles = 0;
    int          limit = 0;
    int          n_pat = 0;

    tb_clkgen #(
        .Period    ( 8 ),
        .RstCycles ( 3 )
    ) u_clkgen (
        .clk_o    ( clk_i    ),
        .arst_n_o ( arst_n_i )
    );

    periph_subsystem #(
        .NumExtIrq ( NumExt )
    ) dut_i (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .req_valid_i  ( req_valid_i  ),
        .req_ready_o  ( req_ready_o  ),
        .req_addr_i   ( req_addr_i   ),
        .req_write_i  ( req_write_i  ),
        .req_wdata_i  ( req_wdata_i  ),
        .resp_valid_o ( resp_valid_o ),
        .resp_ready_i ( resp_ready_i ),
        .resp_rdata_o ( resp_rdata_o ),
        .resp_error_o ( resp_error_o ),
        .ext_irq_i    ( ext_irq_i    ),
        .irq_o        ( irq_o        )
    );

    bind periph_subsystem periph_subsystem_assert u_assert (
        .clk_i          ( clk_i                                   ),
        .arst_n_i       ( arst_n_i                                ),
        .req_valid_i    ( req_valid_i                             ),
        .req_ready_i    ( req_ready_o                             ),
        .req_payload_i  ( {req_addr_i, req_write_i, req_wdata_i} ),
        .resp_valid_i   ( resp_valid_o                            ),
        .resp_ready_i   ( resp_ready_i                            ),
        .resp_payload_i ( {resp_rdata_o, resp_error_o}            ),
        .irq_i          ( irq_o                                   )
    );

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_resp(input reg_resp_t got, input reg_resp_t exp, input logic full);
        if (got.error !== exp.error || (full && got.rdata !== exp.rdata)) begin
            $display("ERR %0t: response rdata %h error %b, expected rdata %h error %b",
                     $time, got.rdata, got.error, exp.rdata, exp.error);
            err_cnt++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: irq_o is %b, expected %b", $time, got, exp);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Request driver, called and returning on a rising edge
    // ------------------------------------------------------------------------
    task automatic send_req(input logic [AddrWidth-1:0] addr, input logic write,
                            input logic [DataWidth-1:0] wdata, input reg_resp_t exp,
                            input logic full);
        exp_q.push_back(exp);
        full_q.push_back(full);
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_write_i <= write;
        req_wdata_i <= wdata;
        @(negedge clk_i);
        while (!req_ready_o) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    task automatic drain();
        req_valid_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
    endtask

    task automatic poll(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] want);
        int   start;
        logic hit;
        start = cycles;
        hit   = 1'b0;
        while (!hit && (cycles - start) < PollLimit) begin
            send_req(addr, 1'b0, '0, '0, 1'b0);
            drain();
            hit = (last_resp.rdata == want);
        end
        if (!hit) begin
            $display("Polling address %h never returned %h within %0d cycles", addr, want,
                     PollLimit);
            err_cnt++;
        end
    endtask

    // Random back-pressure on the response port
    initial begin
        resp_ready_i = 1'b0;
        void'($urandom(32'hf6058da9));
        forever begin
            @(posedge clk_i);
            resp_ready_i <= ($urandom % 4) != 0;
        end
    end

    // Responses are taken at the edge after this negedge
    always @(negedge clk_i) begin
        if (arst_n_i && resp_valid_o && resp_ready_i) begin
            last_resp.rdata = resp_rdata_o;
            last_resp.error = resp_error_o;
            if (exp_q.size() == 0) begin
                $display("A response arrived with no request outstanding at time %0t", $time);
                err_cnt++;
            end else begin
                check_resp(last_resp, exp_q.pop_front(), full_q.pop_front());
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Simulation stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Pattern sequencer
    // ------------------------------------------------------------------------
    initial begin
        logic [3:0]  op;
        logic [31:0] a_w;
        logic [31:0] d_w;
        logic [31:0] x_w;
        reg_resp_t   exp;
        int          test_no;
        int          tests_failed;
        int          err_at_start;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        req_write_i  = 1'b0;
        req_wdata_i  = '0;
        ext_irq_i    = '0;
        $readmemh("verification/periph_patterns.txt", pat_mem);
        while (n_pat < MaxWords / 4 && pat_mem[4 * n_pat][3:0] !== 4'hf) n_pat++;
        limit = n_pat * 256 + 100;
        test_no      = 0;
        tests_failed = 0;
        err_at_start = 0;
        @(posedge arst_n_i);
        @(posedge clk_i);
        for (int idx = 0; idx < n_pat; idx++) begin
            op  = pat_mem[4 * idx][3:0];
            a_w = pat_mem[4 * idx + 1];
            d_w = pat_mem[4 * idx + 2];
            x_w = pat_mem[4 * idx + 3];
            case (op)
                4'h0: begin
                    exp.rdata = '0;
                    exp.error = x_w[0];
                    send_req(a_w[AddrWidth-1:0], 1'b1, d_w, exp, 1'b0);
                end
                4'h1: begin
                    exp.rdata = d_w;
                    exp.error = x_w[0];
                    send_req(a_w[AddrWidth-1:0], 1'b0, '0, exp, 1'b1);
                end
                4'h2: begin
                    drain();
                    ext_irq_i <= d_w[NumExt-1:0];
                    repeat (2) @(posedge clk_i);
                end
                4'h3: begin
                    drain();
                    poll(a_w[AddrWidth-1:0], d_w);
                end
                4'h4: begin
                    drain();
                    @(negedge clk_i);
                    check_irq(irq_o, x_w[0]);
                    @(posedge clk_i);
                end
                4'he: begin
                    drain();
                    test_no++;
                    $display("Test %0d finished with %0d errors", test_no,
                             err_cnt - err_at_start);
                    if (err_cnt != err_at_start) tests_failed++;
                    err_at_start = err_cnt;
                end
                default: begin
                    $display("Pattern %0d has an unknown opcode %h", idx, op);
                    err_cnt++;
                end
            endcase
        end
        drain();
        $display("Tests run %0d, tests failed %0d, errors %0d", test_no, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verification/tb_clkgen.sv
module tb_clkgen #(
    parameter int Period    = 8,
    parameter int RstCycles = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(Period / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RstCycles) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule
